//--- rtl/mrnw_params.svh
`ifndef MRNW_PARAMS_SVH
`define MRNW_PARAMS_SVH

// word width
`define MRNW_WIDTH 8

// logical address space
`define MRNW_NUMADDR 20
`define MRNW_BITADDR 5

// one level of virtual banking, bank count not a power of two
`define MRNW_NUMVBNK 5
`define MRNW_BITVBNK 3
`define MRNW_NUMVROW 4
`define MRNW_BITVROW 2

// port count
`define MRNW_NUMRDPT 2

// cycles from read request to rd_vld
`define MRNW_MEM_DELAY 2

`endif

//--- rtl/mrnw_addr_pkg.sv
package mrnw_addr_pkg;

  // logical address as seen on the ports
  typedef logic [4:0] addr_t;

  // virtual bank index, address modulo bank count
  typedef logic [2:0] bank_t;

  // row inside a bank, address divided by bank count
  typedef logic [1:0] row_t;

  // physical address, bank in the upper bits and row below
  typedef logic [4:0] padr_t;

endpackage

//--- rtl/mrnw_data_pkg.sv
package mrnw_data_pkg;

  // one stored word
  typedef logic [7:0] data_t;

  // everything a read port returns
  typedef struct packed {
    logic                  vld;
    data_t                 dout;
    logic                  serr;
    logic                  derr;
    mrnw_addr_pkg::padr_t  padr;
  } rd_result_t;

endpackage

//--- rtl/mrnw_lookup_if.sv
`timescale 1ns/10ps
`include "mrnw_params.svh"

interface mrnw_lookup_if;
  import mrnw_addr_pkg::*;

  // request side, filled in at the top level
  logic  read;
  addr_t adr;

  // decoded location
  bank_t bank;
  row_t  row;
  padr_t padr;

  // address split
  modport map (
    input  read,
    input  adr,
    output bank,
    output row,
    output padr
  );

  // storage and flag lookups
  modport user (
    input read,
    input adr,
    input bank,
    input row,
    input padr
  );

endinterface

//--- rtl/addr_map.sv
`timescale 1ns/10ps
`include "mrnw_params.svh"

module addr_map #(
  parameter bit USE_IF = 1'b0
) (
  input  mrnw_addr_pkg::addr_t adr,
  output mrnw_addr_pkg::bank_t bank,
  output mrnw_addr_pkg::row_t  row,
  output mrnw_addr_pkg::padr_t padr,
  mrnw_lookup_if.map           lk
);
  import mrnw_addr_pkg::*;

  bank_t bank_c;
  row_t  row_c;
  padr_t padr_c;

  // remainder picks the bank, quotient the row
  assign bank_c = bank_t'(adr % `MRNW_NUMVBNK);
  assign row_c  = row_t'(adr / `MRNW_NUMVBNK);
  assign padr_c = {bank_c, row_c};

  generate
    if (USE_IF) begin : g_lookup
      assign lk.bank = bank_c;
      assign lk.row  = row_c;
      assign lk.padr = padr_c;
      assign bank    = '0;
      assign row     = '0;
      assign padr    = '0;
    end else begin : g_plain
      // lookup port is left alone on the write and injection paths
      assign bank = bank_c;
      assign row  = row_c;
      assign padr = padr_c;
    end
  endgenerate

endmodule

//--- rtl/data_array.sv
`timescale 1ns/10ps
`include "mrnw_params.svh"

module data_array (
  input  logic                 clk,
  input  logic                 write,
  input  mrnw_addr_pkg::addr_t wr_adr,
  input  mrnw_data_pkg::data_t din,
  mrnw_lookup_if.user          rd [`MRNW_NUMRDPT],
  output mrnw_data_pkg::data_t dout [`MRNW_NUMRDPT]
);
  import mrnw_data_pkg::*;

  // flat storage, indexed by logical address
  data_t mem [`MRNW_NUMADDR];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_adr] <= din;
    end
  end

  // read before write on a same-edge collision
  genvar p;
  generate
    for (p = 0; p < `MRNW_NUMRDPT; p++) begin : g_rd
      assign dout[p] = mem[rd[p].adr];
    end
  endgenerate

endmodule

//--- rtl/error_map.sv
`timescale 1ns/10ps
`include "mrnw_params.svh"

module error_map (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      write,
  input  mrnw_addr_pkg::bank_t      wr_bank,
  input  mrnw_addr_pkg::row_t       wr_row,
  input  logic                      err_inj,
  input  logic                      err_dbl,
  input  mrnw_addr_pkg::bank_t      inj_bank,
  input  mrnw_addr_pkg::row_t       inj_row,
  mrnw_lookup_if.user               rd [`MRNW_NUMRDPT],
  output logic [`MRNW_NUMRDPT-1:0]  serr,
  output logic [`MRNW_NUMRDPT-1:0]  derr,
  output logic                      ready
);
  import mrnw_addr_pkg::*;

  // one flag per physical bank and row
  logic serr_q [`MRNW_NUMVBNK][`MRNW_NUMVROW];
  logic derr_q [`MRNW_NUMVBNK][`MRNW_NUMVROW];

  padr_t wr_loc;
  padr_t inj_loc;
  logic  inj_blocked;

  assign wr_loc  = {wr_bank, wr_row};
  assign inj_loc = {inj_bank, inj_row};

  // a write to the same location wins over the injection
  assign inj_blocked = write && (wr_loc == inj_loc);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < `MRNW_NUMVBNK; b++) begin
        for (int r = 0; r < `MRNW_NUMVROW; r++) begin
          serr_q[b][r] <= 1'b0;
          derr_q[b][r] <= 1'b0;
        end
      end
    end else begin
      if (err_inj && !inj_blocked) begin
        if (err_dbl) begin
          derr_q[inj_bank][inj_row] <= 1'b1;
        end else begin
          serr_q[inj_bank][inj_row] <= 1'b1;
        end
      end
      // fresh data has no error
      if (write) begin
        serr_q[wr_bank][wr_row] <= 1'b0;
        derr_q[wr_bank][wr_row] <= 1'b0;
      end
    end
  end

  genvar p;
  generate
    for (p = 0; p < `MRNW_NUMRDPT; p++) begin : g_rd
      assign serr[p] = rd[p].read & serr_q[rd[p].bank][rd[p].row];
      assign derr[p] = rd[p].read & derr_q[rd[p].bank][rd[p].row];
    end
  endgenerate

  // high from the first edge after reset drops
  always_ff @(posedge clk) begin
    ready <= !rst;
  end

endmodule

//--- rtl/read_pipe.sv
`timescale 1ns/10ps
`include "mrnw_params.svh"

module read_pipe (
  input  logic                       clk,
  input  logic                       rst,
  input  mrnw_data_pkg::rd_result_t  in,
  output mrnw_data_pkg::rd_result_t  out
);
  import mrnw_data_pkg::*;

  rd_result_t stage [`MRNW_MEM_DELAY];
  rd_result_t head;

  // idle slots carry no flags and no address
  always_comb begin
    head = in;
    if (!in.vld) begin
      head.serr = 1'b0;
      head.derr = 1'b0;
      head.padr = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MRNW_MEM_DELAY; i++) begin
        stage[i].vld  <= 1'b0;
        stage[i].serr <= 1'b0;
        stage[i].derr <= 1'b0;
        stage[i].padr <= '0;
      end
    end else begin
      stage[0] <= head;
      for (int i = 1; i < `MRNW_MEM_DELAY; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // last stage drives the port directly
  assign out = stage[`MRNW_MEM_DELAY-1];

endmodule

//--- rtl/mrnw_top.sv
`timescale 1ns/10ps
`include "mrnw_params.svh"

module mrnw_top (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic [`MRNW_NUMRDPT-1:0]                           read,
  input  logic [`MRNW_NUMRDPT*`MRNW_BITADDR-1:0]             rd_adr,
  input  logic                                               write,
  input  logic [`MRNW_BITADDR-1:0]                           wr_adr,
  input  logic [`MRNW_WIDTH-1:0]                             din,
  input  logic                                               err_inj,
  input  logic                                               err_dbl,
  input  logic [`MRNW_BITADDR-1:0]                           err_adr,
  output logic [`MRNW_NUMRDPT-1:0]                           rd_vld,
  output logic [`MRNW_NUMRDPT*`MRNW_WIDTH-1:0]               rd_dout,
  output logic [`MRNW_NUMRDPT-1:0]                           rd_serr,
  output logic [`MRNW_NUMRDPT-1:0]                           rd_derr,
  output logic [`MRNW_NUMRDPT*(`MRNW_BITVBNK+`MRNW_BITVROW)-1:0] rd_padr,
  output logic                                               ready
);

  // one decoded request per read port
  mrnw_lookup_if rd_lk [`MRNW_NUMRDPT] ();

  mrnw_data_pkg::data_t     arr_dout [`MRNW_NUMRDPT];
  logic [`MRNW_NUMRDPT-1:0] flag_serr;
  logic [`MRNW_NUMRDPT-1:0] flag_derr;

  mrnw_addr_pkg::bank_t wr_bank;
  mrnw_addr_pkg::row_t  wr_row;
  mrnw_addr_pkg::bank_t inj_bank;
  mrnw_addr_pkg::row_t  inj_row;

  genvar p;
  generate
    for (p = 0; p < `MRNW_NUMRDPT; p++) begin : g_rd
      mrnw_data_pkg::rd_result_t pipe_in;
      mrnw_data_pkg::rd_result_t pipe_out;

      assign rd_lk[p].read = read[p];
      assign rd_lk[p].adr  = rd_adr[p*`MRNW_BITADDR +: `MRNW_BITADDR];

      addr_map #(
        .USE_IF (1'b1)
      ) u_rd_map (
        .adr  (rd_adr[p*`MRNW_BITADDR +: `MRNW_BITADDR]),
        .bank (),
        .row  (),
        .padr (),
        .lk   (rd_lk[p])
      );

      assign pipe_in = '{vld:  read[p],
                         dout: arr_dout[p],
                         serr: flag_serr[p],
                         derr: flag_derr[p],
                         padr: rd_lk[p].padr};

      read_pipe u_pipe (
        .clk (clk),
        .rst (rst),
        .in  (pipe_in),
        .out (pipe_out)
      );

      assign rd_vld[p]  = pipe_out.vld;
      assign rd_serr[p] = pipe_out.serr;
      assign rd_derr[p] = pipe_out.derr;
      assign rd_dout[p*`MRNW_WIDTH +: `MRNW_WIDTH] = pipe_out.dout;
      assign rd_padr[p*(`MRNW_BITVBNK+`MRNW_BITVROW) +: (`MRNW_BITVBNK+`MRNW_BITVROW)] =
        pipe_out.padr;
    end
  endgenerate

  // write and injection maps only use the plain outputs
  addr_map #(
    .USE_IF (1'b0)
  ) u_wr_map (
    .adr  (wr_adr),
    .bank (wr_bank),
    .row  (wr_row),
    .padr (),
    .lk   (rd_lk[0])
  );

  addr_map #(
    .USE_IF (1'b0)
  ) u_inj_map (
    .adr  (err_adr),
    .bank (inj_bank),
    .row  (inj_row),
    .padr (),
    .lk   (rd_lk[0])
  );

  data_array u_array (
    .clk    (clk),
    .write  (write),
    .wr_adr (wr_adr),
    .din    (din),
    .rd     (rd_lk),
    .dout   (arr_dout)
  );

  error_map u_errs (
    .clk      (clk),
    .rst      (rst),
    .write    (write),
    .wr_bank  (wr_bank),
    .wr_row   (wr_row),
    .err_inj  (err_inj),
    .err_dbl  (err_dbl),
    .inj_bank (inj_bank),
    .inj_row  (inj_row),
    .rd       (rd_lk),
    .serr     (flag_serr),
    .derr     (flag_derr),
    .ready    (ready)
  );

endmodule

//--- testbench/mrnw_chk.sv
`timescale 1ns/10ps
`include "mrnw_params.svh"

module mrnw_chk (
  input logic                                                   clk,
  input logic                                                   rst,
  input logic [`MRNW_NUMRDPT-1:0]                               read,
  input logic [`MRNW_NUMRDPT*`MRNW_BITADDR-1:0]                 rd_adr,
  input logic                                                   write,
  input logic [`MRNW_BITADDR-1:0]                               wr_adr,
  input logic                                                   err_inj,
  input logic [`MRNW_BITADDR-1:0]                               err_adr,
  input logic [`MRNW_NUMRDPT-1:0]                               rd_vld,
  input logic [`MRNW_NUMRDPT-1:0]                               rd_serr,
  input logic [`MRNW_NUMRDPT-1:0]                               rd_derr,
  input logic [`MRNW_NUMRDPT*(`MRNW_BITVBNK+`MRNW_BITVROW)-1:0] rd_padr,
  input logic                                                   ready
);
  localparam int PW = `MRNW_BITVBNK + `MRNW_BITVROW;
  // read sampled at edge N shows on rd_vld at edge N+MEM_DELAY
  localparam int LAT = `MRNW_MEM_DELAY;

  logic        rst_q = 1'b0;
  logic        armed = 1'b0;
  int unsigned settle = 0;
  // count of failed assertions
  int unsigned fails = 0;

  always @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      armed  <= 1'b1;
      settle <= 0;
    end else if (settle < 15) begin
      settle <= settle + 1;
    end
  end

  ready_low_in_reset: assert property (@(posedge clk) rst_q |-> !ready)
    else begin
      fails++;
      $error("ready high while reset is applied");
    end

  vld_follows_read: assert property (@(posedge clk) disable iff (rst)
    settle > LAT |-> rd_vld == $past(read, LAT))
    else begin
      fails++;
      $error("rd_vld does not match delayed read");
    end

  wr_inj_in_range: assert property (@(posedge clk)
    (!write || wr_adr < `MRNW_NUMADDR) && (!err_inj || err_adr < `MRNW_NUMADDR))
    else begin
      fails++;
      $error("write or injection address out of range");
    end

  genvar p;
  generate
    for (p = 0; p < `MRNW_NUMRDPT; p++) begin : g_port
      idle_is_quiet: assert property (@(posedge clk) disable iff (!armed)
        !rd_vld[p] |-> !rd_serr[p] && !rd_derr[p] && rd_padr[p*PW +: PW] == '0)
        else begin
          fails++;
          $error("flags or address present without rd_vld");
        end

      rd_in_range: assert property (@(posedge clk)
        read[p] |-> rd_adr[p*`MRNW_BITADDR +: `MRNW_BITADDR] < `MRNW_NUMADDR)
        else begin
          fails++;
          $error("read address out of range");
        end
    end
  endgenerate

endmodule

//--- testbench/mrnw_tb.sv
`timescale 1ns/10ps
`include "mrnw_params.svh"

module mrnw_tb;
  import mrnw_addr_pkg::*;
  import mrnw_data_pkg::*;

  localparam int NP = `MRNW_NUMRDPT;
  localparam int AW = `MRNW_BITADDR;
  localparam int DW = `MRNW_WIDTH;
  localparam int PW = `MRNW_BITVBNK + `MRNW_BITVROW;
  localparam int NA = `MRNW_NUMADDR;

  // reset, fill, sweep, traffic, injection, rewrite plus sweep, drain
  localparam int TOTAL_CYC = 10 + NA + NA + 210 + 75 + 2 * NA + `MRNW_MEM_DELAY + 3;
  localparam int LIMIT_CYC = TOTAL_CYC * 3 / 2;

  typedef rd_result_t [NP-1:0] exp_row_t;

  logic             clk = 1'b0;
  logic             rst;
  logic [NP-1:0]    read;
  logic [NP*AW-1:0] rd_adr;
  logic             write;
  logic [AW-1:0]    wr_adr;
  logic [DW-1:0]    din;
  logic             err_inj;
  logic             err_dbl;
  logic [AW-1:0]    err_adr;
  logic [NP-1:0]    rd_vld;
  logic [NP*DW-1:0] rd_dout;
  logic [NP-1:0]    rd_serr;
  logic [NP-1:0]    rd_derr;
  logic [NP*PW-1:0] rd_padr;
  logic             ready;

  // inputs for the next step
  logic          n_rst;
  logic [NP-1:0] n_read;
  addr_t         n_adr [NP];
  logic          n_write;
  addr_t         n_wadr;
  data_t         n_din;
  logic          n_inj;
  logic          n_dbl;
  addr_t         n_iadr;

  // shadow state
  data_t    shadow [NA];
  logic     sflag [NA];
  logic     dflag [NA];
  exp_row_t exp_q [$];

  logic [31:0] seed = 32'hee49;
  int          cycles = 0;
  int          errors = 0;
  logic        rst_last;
  logic        rst_seen = 1'b0;
  logic [31:0] r;
  addr_t       a;

  mrnw_top dut (.*);

  bind mrnw_top mrnw_chk chk (.*);

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic addr_t rand_addr();
    logic [31:0] v;
    v = next_rand();
    return addr_t'(v[31:8] % NA);
  endfunction

  // addresses fill banks 0 to 4 of row 0, then row 1, and so on
  function automatic padr_t phys_addr(input addr_t adr);
    padr_t pa;
    int    cnt;
    pa  = '0;
    cnt = 0;
    for (int rw = 0; rw < `MRNW_NUMVROW; rw++) begin
      for (int b = 0; b < `MRNW_NUMVBNK; b++) begin
        if (cnt == adr) begin
          pa = {bank_t'(b), row_t'(rw)};
        end
        cnt++;
      end
    end
    return pa;
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "first error, run stopped");
  endtask

  task automatic clear_next();
    n_read  = '0;
    n_adr   = '{default: '0};
    n_write = 1'b0;
    n_wadr  = '0;
    n_din   = '0;
    n_inj   = 1'b0;
    n_dbl   = 1'b0;
    n_iadr  = '0;
  endtask

  // one clock of stimulus plus the matching expectation
  task automatic step();
    exp_row_t         e;
    logic [NP*AW-1:0] adr_bus;
    for (int p = 0; p < NP; p++) begin
      adr_bus[p*AW +: AW] = n_adr[p];
      e[p]     = '0;
      e[p].vld = n_read[p];
      if (n_read[p]) begin
        e[p].dout = shadow[n_adr[p]];
        e[p].serr = sflag[n_adr[p]];
        e[p].derr = dflag[n_adr[p]];
        e[p].padr = phys_addr(n_adr[p]);
      end
    end
    @(posedge clk);
    rst     <= n_rst;
    read    <= n_read;
    rd_adr  <= adr_bus;
    write   <= n_write;
    wr_adr  <= n_wadr;
    din     <= n_din;
    err_inj <= n_inj;
    err_dbl <= n_dbl;
    err_adr <= n_iadr;
    exp_q.push_back(e);
    if (!n_rst && n_inj) begin
      if (n_dbl) begin
        dflag[n_iadr] = 1'b1;
      end else begin
        sflag[n_iadr] = 1'b1;
      end
    end
    // write applied last so it wins over a same-location injection
    if (n_write) begin
      shadow[n_wadr] = n_din;
      sflag[n_wadr]  = 1'b0;
      dflag[n_wadr]  = 1'b0;
    end
  endtask

  initial forever #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > LIMIT_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT_CYC);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  // protocol failures flagged by the bound checker
  always @(negedge clk) begin
    if (dut.chk.fails != 0) begin
      $display("Protocol assertion in the bound checker failed at %0t", $time);
      $display("TESTBENCH FAILED");
      $fatal(1, "checker failure");
    end
  end

  // outputs settle long before the falling edge
  always @(negedge clk) begin : check_outputs
    exp_row_t e;
    // entry from the drive edge leaves the pipe MEM_DELAY edges later
    if (exp_q.size() > `MRNW_MEM_DELAY) begin
      e = exp_q.pop_front();
      for (int p = 0; p < NP; p++) begin
        assert (rd_vld[p] === e[p].vld)
          else report_mismatch($sformatf("port %0d rd_vld %b, expected %b",
                                         p, rd_vld[p], e[p].vld));
        if (e[p].vld) begin
          assert (rd_dout[p*DW +: DW] === e[p].dout)
            else report_mismatch($sformatf("port %0d rd_dout %h, expected %h",
                                           p, rd_dout[p*DW +: DW], e[p].dout));
        end
        assert (rd_serr[p] === e[p].serr && rd_derr[p] === e[p].derr)
          else report_mismatch($sformatf("port %0d serr/derr %b%b, expected %b%b",
                                         p, rd_serr[p], rd_derr[p], e[p].serr, e[p].derr));
        assert (rd_padr[p*PW +: PW] === e[p].padr)
          else report_mismatch($sformatf("port %0d rd_padr %h, expected %h",
                                         p, rd_padr[p*PW +: PW], e[p].padr));
      end
    end
    if (rst_seen) begin
      assert (ready === !rst_last)
        else report_mismatch($sformatf("ready %b, expected %b", ready, !rst_last));
    end
    rst_last = rst;
    rst_seen = 1'b1;
  end

  initial begin
    rst = 1'b1;
    {read, rd_adr, write, wr_adr, din, err_inj, err_dbl, err_adr} = '0;
    for (int i = 0; i < NA; i++) begin
      sflag[i] = 1'b0;
      dflag[i] = 1'b0;
    end
    clear_next();
    n_rst = 1'b1;
    repeat (10) step();
    n_rst = 1'b0;

    for (int i = 0; i < NA; i++) begin
      r = next_rand();
      clear_next();
      n_write = 1'b1;
      n_wadr  = addr_t'(i);
      n_din   = r[7:0];
      step();
    end

    // every address on both ports
    for (int i = 0; i < NA; i++) begin
      clear_next();
      n_read   = '1;
      n_adr[0] = addr_t'(i);
      n_adr[1] = addr_t'(NA - 1 - i);
      step();
    end

    // read and write collide, then the new word is read back
    repeat (5) begin
      a = rand_addr();
      r = next_rand();
      clear_next();
      n_read   = 2'b01;
      n_adr[0] = a;
      n_write  = 1'b1;
      n_wadr   = a;
      n_din    = r[7:0];
      step();
      clear_next();
      n_read   = 2'b11;
      n_adr[0] = a;
      n_adr[1] = a;
      step();
    end
    repeat (200) begin
      r = next_rand();
      clear_next();
      n_read   = r[1:0];
      n_adr[0] = rand_addr();
      n_adr[1] = rand_addr();
      n_write  = r[2];
      n_wadr   = r[3] ? n_adr[0] : rand_addr();
      n_din    = r[15:8];
      step();
    end

    for (int i = 0; i < 5; i++) begin
      a = rand_addr();
      clear_next();
      n_inj  = 1'b1;
      n_dbl  = i[0];
      n_iadr = a;
      step();
      clear_next();
      n_read   = 2'b11;
      n_adr[0] = a;
      n_adr[1] = addr_t'((a + 1) % NA);
      step();
    end
    repeat (65) begin
      r = next_rand();
      clear_next();
      n_read   = r[1:0];
      n_adr[0] = rand_addr();
      n_adr[1] = rand_addr();
      n_inj    = r[2];
      n_dbl    = r[3];
      n_iadr   = r[4] ? n_adr[0] : rand_addr();
      n_write  = (r[7:5] == 3'd0);
      n_wadr   = rand_addr();
      n_din    = r[15:8];
      step();
    end

    // even addresses race an injection, odd ones mark the next address
    for (int i = 0; i < NA; i++) begin
      r = next_rand();
      clear_next();
      n_write = 1'b1;
      n_wadr  = addr_t'(i);
      n_din   = r[7:0];
      n_inj   = 1'b1;
      n_dbl   = r[8];
      n_iadr  = i[0] ? addr_t'((i + 1) % NA) : addr_t'(i);
      step();
    end
    for (int i = 0; i < NA; i++) begin
      clear_next();
      n_read   = '1;
      n_adr[0] = addr_t'(i);
      n_adr[1] = addr_t'((i + 10) % NA);
      step();
    end

    clear_next();
    repeat (`MRNW_MEM_DELAY + 3) step();
    if (errors == 0 && dut.chk.fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+rtl
rtl/mrnw_addr_pkg.sv
rtl/mrnw_data_pkg.sv
rtl/mrnw_lookup_if.sv
rtl/addr_map.sv
rtl/data_array.sv
rtl/error_map.sv
rtl/read_pipe.sv
rtl/mrnw_top.sv
testbench/mrnw_chk.sv
testbench/mrnw_tb.sv
